//--- dbg_ctrl.sv
module dbg_ctrl (
   input  logic           clk,
   input  logic           arst_n_i,
   input  dbg_pkg::byte_t rx_data_i,
   input  logic           rx_valid_i,
   output dbg_pkg::byte_t tx_data_o,
   output logic           tx_start_o,
   input  logic           tx_busy_i,
   output logic           mem_req_o,
   output logic           mem_we_o,
   output dbg_pkg::addr_t mem_addr_o,
   output dbg_pkg::word_t mem_wdata_o,
   input  logic           mem_ack_i,
   input  dbg_pkg::word_t mem_rdata_i
);

   import dbg_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      GET_ADDR,
      GET_HI,
      GET_LO,
      MEM_REQ,
      MEM_REL,
      SEND,
      SEND_WAIT
   } ctrl_state_t;

   ctrl_state_t state;
   byte_t       opcode_q;
   addr_t       addr_q;
   word_t       wdata_q;
   logic        req_q;
   logic        we_q;
   logic        tx_start_q;
   // Bytes still to send, oldest in the upper half
   word_t       resp_buf;
   logic [1:0]  resp_cnt;
   logic        tx_done;

   // Start pulse seen and the frame has left the transmitter
   assign tx_done = !tx_start_q && !tx_busy_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= IDLE;
         req_q      <= 1'b0;
         we_q       <= 1'b0;
         tx_start_q <= 1'b0;
         resp_cnt   <= '0;
      end else begin
         tx_start_q <= 1'b0;
         case (state)
            IDLE: begin
               if (rx_valid_i) begin
                  if (rx_data_i == OP_WRITE || rx_data_i == OP_READ) begin
                     state <= GET_ADDR;
                  end else begin
                     // Unknown opcode ends the frame here
                     resp_cnt <= 2'd1;
                     state    <= SEND;
                  end
               end
            end
            GET_ADDR: begin
               if (rx_valid_i) begin
                  if (opcode_q == OP_WRITE) begin
                     state <= GET_HI;
                  end else begin
                     we_q  <= 1'b0;
                     req_q <= 1'b1;
                     state <= MEM_REQ;
                  end
               end
            end
            GET_HI: begin
               if (rx_valid_i) begin
                  state <= GET_LO;
               end
            end
            GET_LO: begin
               if (rx_valid_i) begin
                  we_q  <= 1'b1;
                  req_q <= 1'b1;
                  state <= MEM_REQ;
               end
            end
            MEM_REQ: begin
               if (mem_ack_i) begin
                  req_q    <= 1'b0;
                  resp_cnt <= we_q ? 2'd1 : 2'd2;
                  state    <= MEM_REL;
               end
            end
            MEM_REL: begin
               // Four-phase, ack must be low before anything else
               if (!mem_ack_i) begin
                  state <= SEND;
               end
            end
            SEND: begin
               if (!tx_busy_i) begin
                  tx_start_q <= 1'b1;
                  resp_cnt   <= resp_cnt - 1'b1;
                  state      <= SEND_WAIT;
               end
            end
            SEND_WAIT: begin
               if (tx_done) begin
                  state <= (resp_cnt != 2'd0) ? SEND : IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Frame fields and response bytes
   always_ff @(posedge clk) begin
      case (state)
         IDLE: begin
            if (rx_valid_i) begin
               opcode_q <= rx_data_i;
               resp_buf <= {RESP_BAD_OP, 8'h00};
            end
         end
         GET_ADDR: begin
            if (rx_valid_i) begin
               addr_q <= rx_data_i;
            end
         end
         GET_HI: begin
            if (rx_valid_i) begin
               wdata_q[15:8] <= rx_data_i;
            end
         end
         GET_LO: begin
            if (rx_valid_i) begin
               wdata_q[7:0] <= rx_data_i;
            end
         end
         MEM_REQ: begin
            if (mem_ack_i) begin
               resp_buf <= we_q ? {RESP_WR_OK, 8'h00} : mem_rdata_i;
            end
         end
         SEND_WAIT: begin
            if (tx_done) begin
               resp_buf <= {resp_buf[7:0], 8'h00};
            end
         end
         default: ;
      endcase
   end

   assign tx_data_o   = resp_buf[15:8];
   assign tx_start_o  = tx_start_q;
   assign mem_req_o   = req_q;
   assign mem_we_o    = we_q;
   assign mem_addr_o  = addr_q;
   assign mem_wdata_o = wdata_q;

endmodule

//--- dbg_mem.sv
module dbg_mem (
   input  logic           clk,
   input  logic           arst_n_i,
   input  logic           mem_req_i,
   input  logic           mem_we_i,
   input  dbg_pkg::addr_t mem_addr_i,
   input  dbg_pkg::word_t mem_wdata_i,
   output logic           mem_ack_o,
   output dbg_pkg::word_t mem_rdata_o
);

   import dbg_pkg::*;

   word_t                 mem_q [MEM_DEPTH];
   word_t                 rdata_q;
   logic [WAIT_CNT_W-1:0] wait_cnt;
   logic                  ack_q;
   logic                  access;

   // Wait states are over, do the access this cycle
   assign access = mem_req_i && !ack_q && (wait_cnt == WAIT_CNT_LAST);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wait_cnt <= '0;
         ack_q    <= 1'b0;
      end else begin
         if (!mem_req_i) begin
            // Requester released, return to zero
            wait_cnt <= '0;
            ack_q    <= 1'b0;
         end else if (access) begin
            ack_q <= 1'b1;
         end else if (!ack_q) begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= mem_q[mem_addr_i];
         if (mem_we_i) begin
            mem_q[mem_addr_i] <= mem_wdata_i;
         end
      end
   end

   assign mem_ack_o   = ack_q;
   assign mem_rdata_o = rdata_q;

endmodule

//--- dbg_pkg.sv
package dbg_pkg;

   // Data path widths
   localparam int BYTE_W    = 8;
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 16;
   localparam int MEM_DEPTH = 2 ** ADDR_W;

   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] word_t;

   // UART bit timing in clock cycles, shared by rx and tx
   localparam int CLKS_PER_BIT = 8;
   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

   localparam logic [BIT_CNT_W-1:0] BIT_CNT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
   // Counter value at the middle of a bit
   localparam logic [BIT_CNT_W-1:0] BIT_CNT_HALF = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

   // Tile memory wait states before ack
   localparam int MEM_WAIT_CYCLES = 3;
   localparam int WAIT_CNT_W      = $clog2(MEM_WAIT_CYCLES + 1);

   localparam logic [WAIT_CNT_W-1:0] WAIT_CNT_LAST = WAIT_CNT_W'(MEM_WAIT_CYCLES);

   // Command opcodes
   localparam byte_t OP_WRITE = 8'h01;
   localparam byte_t OP_READ  = 8'h02;

   // Single-byte responses
   localparam byte_t RESP_WR_OK  = 8'hA5;
   localparam byte_t RESP_BAD_OP = 8'hEE;

endpackage

//--- dbg_tile_top.sv
module dbg_tile_top (
   input  logic clk,
   input  logic arst_n_i,
   input  logic uart_rx_i,
   output logic uart_tx_o
);

   import dbg_pkg::*;

   // UART side
   byte_t rx_data;
   logic  rx_valid;
   byte_t tx_data;
   logic  tx_start;
   logic  tx_busy;

   // Tile memory handshake
   logic  mem_req;
   logic  mem_we;
   addr_t mem_addr;
   word_t mem_wdata;
   logic  mem_ack;
   word_t mem_rdata;

   dbg_uart_rx u_uart_rx (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .uart_rx_i  (uart_rx_i),
      .rx_data_o  (rx_data),
      .rx_valid_o (rx_valid)
   );

   dbg_uart_tx u_uart_tx (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .tx_data_i  (tx_data),
      .tx_start_i (tx_start),
      .tx_busy_o  (tx_busy),
      .uart_tx_o  (uart_tx_o)
   );

   dbg_ctrl u_ctrl (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .rx_data_i   (rx_data),
      .rx_valid_i  (rx_valid),
      .tx_data_o   (tx_data),
      .tx_start_o  (tx_start),
      .tx_busy_i   (tx_busy),
      .mem_req_o   (mem_req),
      .mem_we_o    (mem_we),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata),
      .mem_ack_i   (mem_ack),
      .mem_rdata_i (mem_rdata)
   );

   // Stands in for the DRAM bridge
   dbg_mem u_mem (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .mem_req_i   (mem_req),
      .mem_we_i    (mem_we),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_ack_o   (mem_ack),
      .mem_rdata_o (mem_rdata)
   );

endmodule

//--- dbg_uart_rx.sv
module dbg_uart_rx (
   input  logic          clk,
   input  logic          arst_n_i,
   input  logic          uart_rx_i,
   output dbg_pkg::byte_t rx_data_o,
   output logic          rx_valid_o
);

   import dbg_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t            state;
   logic                 rx_meta;
   logic                 rx_sync;
   logic [BIT_CNT_W-1:0] clk_cnt;
   logic [2:0]           bit_idx;
   byte_t                shift_q;
   logic                 valid_q;

   // Line idles high, so the synchronizer resets to one
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= uart_rx_i;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state   <= RX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               bit_idx <= '0;
               if (!rx_sync) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (clk_cnt == BIT_CNT_HALF) begin
                  clk_cnt <= '0;
                  // A short glitch is not a start bit
                  state   <= rx_sync ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (clk_cnt == BIT_CNT_LAST) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (clk_cnt == BIT_CNT_LAST) begin
                  state   <= RX_IDLE;
                  // Low stop bit drops the byte
                  valid_q <= rx_sync;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB arrives first
   always_ff @(posedge clk) begin
      if (state == RX_DATA && clk_cnt == BIT_CNT_LAST) begin
         shift_q <= {rx_sync, shift_q[7:1]};
      end
   end

   assign rx_data_o  = shift_q;
   assign rx_valid_o = valid_q;

endmodule

//--- dbg_uart_tx.sv
module dbg_uart_tx (
   input  logic          clk,
   input  logic          arst_n_i,
   input  dbg_pkg::byte_t tx_data_i,
   input  logic          tx_start_i,
   output logic          tx_busy_o,
   output logic          uart_tx_o
);

   import dbg_pkg::*;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   tx_state_t            state;
   logic [BIT_CNT_W-1:0] clk_cnt;
   logic [2:0]           bit_idx;
   byte_t                shift_q;
   logic                 tx_q;
   logic                 busy_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state   <= TX_IDLE;
         clk_cnt <= '0;
         bit_idx <= '0;
         tx_q    <= 1'b1;
         busy_q  <= 1'b0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (tx_start_i) begin
                  state   <= TX_START;
                  clk_cnt <= '0;
                  tx_q    <= 1'b0;
                  busy_q  <= 1'b1;
               end
            end
            TX_START: begin
               if (clk_cnt == BIT_CNT_LAST) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  tx_q    <= shift_q[0];
                  state   <= TX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            TX_DATA: begin
               if (clk_cnt == BIT_CNT_LAST) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     tx_q  <= 1'b1;
                     state <= TX_STOP;
                  end else begin
                     // Next bit before the shift takes effect
                     tx_q <= shift_q[1];
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            TX_STOP: begin
               if (clk_cnt == BIT_CNT_LAST) begin
                  busy_q <= 1'b0;
                  state  <= TX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_start_i) begin
         shift_q <= tx_data_i;
      end else if (state == TX_DATA && clk_cnt == BIT_CNT_LAST) begin
         shift_q <= {1'b0, shift_q[7:1]};
      end
   end

   assign tx_busy_o = busy_q;
   assign uart_tx_o = tx_q;

endmodule

//--- dbg_vectors.txt
// opcode address write_data byte_count response
// response is right aligned, first byte received is the upper one
01 00 1234 1 00A5
01 FF BEEF 1 00A5
02 00 0000 2 1234
02 FF 0000 2 BEEF
01 10 0A0B 1 00A5
01 11 C0DE 1 00A5
01 10 5566 1 00A5
02 10 0000 2 5566
02 11 0000 2 C0DE
7F 00 0000 1 00EE
02 11 0000 2 C0DE
01 80 FFFF 1 00A5
02 80 0000 2 FFFF
00 00 0000 1 00EE
01 7F 0001 1 00A5
02 7F 0000 2 0001
02 80 0000 2 FFFF
02 00 0000 2 1234

//--- sim.f
dbg_pkg.sv
dbg_uart_rx.sv
dbg_uart_tx.sv
dbg_ctrl.sv
dbg_mem.sv
dbg_tile_top.sv
tb_dbg_tile.sv

//--- tb_dbg_tile.sv
module tb_dbg_tile;

   import dbg_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int MAX_VEC    = 64;
   // Opcode, address, write data, byte count, response word
   localparam int VEC_FIELDS = 5;

   logic clk;
   logic arst_n_i;
   logic uart_rx_i;
   logic uart_tx_o;

   logic [15:0] vec_mem [MAX_VEC*VEC_FIELDS];
   byte_t       rx_q [$];
   int          n_vec;
   int          start_cnt;
   int          exp_total;
   int          err_cnt;
   int          check_cnt;
   int          idle_low_cnt;
   int          seed;
   int          gap;
   bit          vectors_loaded;
   byte_t       op;
   addr_t       addr;
   word_t       wdata;
   int          resp_cnt;
   word_t       exp_resp;
   word_t       got_resp;

   dbg_tile_top u_dut (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         $display("FAILED at time %0t: %s got 'h%0h expected 'h%0h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_and_finish();
      $display("Run done: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   // Host side 8N1 serializer with LSB first
   task automatic send_byte(input byte_t data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #2 uart_rx_i = frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk);
      end
   endtask

   // One response byte sampled near the middle of each bit
   task automatic recv_byte(output byte_t data);
      @(negedge uart_tx_o);
      start_cnt++;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx_o !== 1'b0) begin
         $display("Error at time %0t: response start bit did not hold low", $time);
         err_cnt++;
      end
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         data[i] = uart_tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
         $display("Error at time %0t: stop bit of response byte is low", $time);
         err_cnt++;
      end
   endtask

   // Frame length follows the opcode
   task automatic run_command(input byte_t opcode, input addr_t a, input word_t d);
      send_byte(opcode);
      if (opcode == OP_WRITE || opcode == OP_READ) begin
         send_byte(a);
      end
      if (opcode == OP_WRITE) begin
         send_byte(d[15:8]);
         send_byte(d[7:0]);
      end
   endtask

   // Every byte the DUT sends ends up in rx_q
   initial begin
      byte_t b;
      wait (arst_n_i === 1'b1);
      forever begin
         recv_byte(b);
         rx_q.push_back(b);
      end
   end

   // Watchdog sized from the vector count
   initial begin
      longint limit;
      wait (vectors_loaded);
      limit = longint'(n_vec) * 6 * 10 * CLKS_PER_BIT * CLK_PERIOD + 2000;
      #(limit);
      $display("Error at time %0t: timeout, the DUT did not answer in time", $time);
      err_cnt++;
      report_and_finish();
   end

   initial begin
      arst_n_i       = 1'b0;
      uart_rx_i      = 1'b1;
      err_cnt        = 0;
      check_cnt      = 0;
      start_cnt      = 0;
      exp_total      = 0;
      idle_low_cnt   = 0;
      n_vec          = 0;
      seed           = 32'hdd09;
      vectors_loaded = 1'b0;

      $readmemh("dbg_vectors.txt", vec_mem);
      // Each command answers with at least one byte
      while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec*VEC_FIELDS+3]) &&
             vec_mem[n_vec*VEC_FIELDS+3] != 16'd0) begin
         n_vec++;
      end
      if (n_vec == 0) begin
         $display("Error: no command vectors were loaded from dbg_vectors.txt");
         err_cnt++;
      end
      vectors_loaded = 1'b1;

      repeat (4) @(posedge clk);
      #2 arst_n_i = 1'b1;

      // Line must stay idle before any command
      repeat (20 * CLKS_PER_BIT) begin
         @(negedge clk);
         if (uart_tx_o !== 1'b1) begin
            idle_low_cnt++;
         end
      end
      check_value("uart_tx_o low cycles while idle", idle_low_cnt, 0);

      for (int v = 0; v < n_vec; v++) begin
         op       = vec_mem[v*VEC_FIELDS][7:0];
         addr     = vec_mem[v*VEC_FIELDS+1][7:0];
         wdata    = vec_mem[v*VEC_FIELDS+2];
         resp_cnt = vec_mem[v*VEC_FIELDS+3];
         exp_resp = vec_mem[v*VEC_FIELDS+4];

         gap = $random(seed) & 15;
         repeat (gap) @(posedge clk);

         run_command(op, addr, wdata);
         exp_total += resp_cnt;
         while (rx_q.size() < resp_cnt) begin
            @(posedge clk);
         end
         // First byte ends up in the upper half
         got_resp = '0;
         for (int k = 0; k < resp_cnt; k++) begin
            got_resp = {got_resp[7:0], rx_q.pop_front()};
         end
         check_value($sformatf("response of command %0d", v), got_resp, exp_resp);

         // Any extra byte would have started by now
         repeat (2 * CLKS_PER_BIT) @(posedge clk);
         check_value("response bytes so far", start_cnt, exp_total);
      end

      repeat (12 * CLKS_PER_BIT) @(posedge clk);
      check_value("response bytes in total", start_cnt, exp_total);
      report_and_finish();
   end

endmodule
